//--- common/cksum_defines.svh
`ifndef CKSUM_DEFINES_SVH
`define CKSUM_DEFINES_SVH

////////////////////////////////
// Bus geometry
////////////////////////////////

// Wishbone data width
`define CKSUM_DATA_W 32
// Word address width, one word per register
`define CKSUM_ADR_W 2

////////////////////////////////
// Buffering and arithmetic
////////////////////////////////

// Packet byte FIFO, host side
`define CKSUM_IN_DEPTH 8
// Finished checksum FIFO
`define CKSUM_RES_DEPTH 4
// Fletcher-16 folds both sums modulo 255
`define CKSUM_MOD 255

`endif

//--- common/cksum_pkg.sv
`default_nettype none

`include "cksum_defines.svh"

package cksum_pkg;

    // Master to slave, held stable until ack
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`CKSUM_ADR_W-1:0]   adr;
        logic [`CKSUM_DATA_W-1:0]  dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                      ack;
        logic [`CKSUM_DATA_W-1:0]  dat;
    } wb_rsp_t;

    // One packet byte, last flag on top as in the DATA register
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } in_item_t;

    // Finished checksum, sum2 high and sum1 low
    typedef struct packed {
        logic [7:0] sum2;
        logic [7:0] sum1;
    } res_item_t;

    // Register map, word addressed
    typedef enum logic [`CKSUM_ADR_W-1:0] {
        REG_DATA   = 2'd0,
        REG_RESULT = 2'd1,
        REG_STATUS = 2'd2
    } reg_addr_e;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
)
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     push,
    input  wire payload_t                 wr_data,
    input  wire logic                     pop,
    output payload_t                      rd_data,
    output logic                          empty,
    output logic                          full,
    // One bit wider than the pointers so it can reach DEPTH
    output logic [$clog2(DEPTH):0]        level
);

    localparam int PTR_W = $clog2(DEPTH);

    // Circular storage and its pointers
    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // Accepted operations only
    logic push_ok;
    logic pop_ok;

    // Flags come straight from the counter
    assign empty   = (level == '0);
    assign full    = (level == DEPTH[PTR_W:0]);
    // Push when full and pop when empty are dropped
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    ////////////////////////////////
    // Fill counter and pointers
    ////////////////////////////////
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            level  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            // Push and pop together cancel out
            case ({push_ok, pop_ok})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
            // Pointers wrap on their own, DEPTH is a power of two
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    ////////////////////////////////
    // Storage and read register
    ////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= wr_data;
        // Head word lands here the cycle after the pop
        if (pop_ok)
            rd_data <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- source/fletcher_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "cksum_defines.svh"

module fletcher_engine
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire cksum_pkg::in_item_t  in_data,
    input  wire logic                 in_empty,
    output logic                      in_pop,
    input  wire logic                 res_full,
    output logic                      res_push,
    output cksum_pkg::res_item_t      res_data
);

    localparam logic [8:0] MOD = 9'(`CKSUM_MOD);

    // Stage 1 is the pop, stage 2 the accumulate
    logic                  in_valid_q;
    logic [7:0]            sum1_q;
    logic [7:0]            sum2_q;
    logic [8:0]            sum1_raw;
    logic [8:0]            sum2_raw;
    logic [7:0]            sum1_nxt;
    logic [7:0]            sum2_nxt;
    logic                  res_push_q;
    cksum_pkg::res_item_t  res_q;
    logic                  last_in_flight;

    ////////////////////////////////
    // Pop control
    ////////////////////////////////
    // A result still travelling to the result FIFO is not counted in res_full yet
    assign last_in_flight = (in_valid_q && in_data.last) || res_push_q;
    assign in_pop         = !in_empty && !res_full && !last_in_flight;

    ////////////////////////////////
    // Modulo 255 sums
    ////////////////////////////////
    // Sum1 first, sum2 folds in the new sum1
    // One conditional subtract is enough, both operands stay below 255
    assign sum1_raw = {1'b0, sum1_q} + {1'b0, in_data.data};
    assign sum1_nxt = (sum1_raw >= MOD) ? 8'(sum1_raw - MOD) : sum1_raw[7:0];
    assign sum2_raw = {1'b0, sum2_q} + {1'b0, sum1_nxt};
    assign sum2_nxt = (sum2_raw >= MOD) ? 8'(sum2_raw - MOD) : sum2_raw[7:0];

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            in_valid_q <= 1'b0;
            res_push_q <= 1'b0;
            sum1_q     <= '0;
            sum2_q     <= '0;
        end
        else
        begin
            // FIFO read register holds a fresh byte one cycle after the pop
            in_valid_q <= in_pop;
            res_push_q <= in_valid_q && in_data.last;
            if (in_valid_q)
            begin
                // Next packet starts from zero
                if (in_data.last)
                begin
                    sum1_q <= '0;
                    sum2_q <= '0;
                end
                else
                begin
                    sum1_q <= sum1_nxt;
                    sum2_q <= sum2_nxt;
                end
            end
        end
    end

    // Final pair of the packet
    always_ff @(posedge clk)
    begin
        if (in_valid_q && in_data.last)
            res_q <= '{sum2: sum2_nxt, sum1: sum1_nxt};
    end

    assign res_push = res_push_q;
    assign res_data = res_q;

endmodule

`default_nettype wire

//--- source/wb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cksum_defines.svh"

module wb_ctrl
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire cksum_pkg::wb_req_t              wb_req,
    output cksum_pkg::wb_rsp_t                   wb_rsp,
    // Input FIFO push side
    output logic                                 in_push,
    output cksum_pkg::in_item_t                  in_data,
    input  wire logic                            in_full,
    input  wire logic [$clog2(`CKSUM_IN_DEPTH):0]  in_level,
    // Result FIFO pop side
    output logic                                 res_pop,
    input  wire cksum_pkg::res_item_t            res_data,
    input  wire logic                            res_empty,
    input  wire logic [$clog2(`CKSUM_RES_DEPTH):0] res_level
);

    localparam int IN_LVL_W  = $clog2(`CKSUM_IN_DEPTH) + 1;
    localparam int RES_LVL_W = $clog2(`CKSUM_RES_DEPTH) + 1;
    localparam int RES_W     = $bits(cksum_pkg::res_item_t);

    // STATUS layout, each field zero extended
    localparam int STAT_IN_LVL_LSB  = 0;
    localparam int STAT_RES_LVL_LSB = 8;
    localparam int STAT_IN_FULL     = 16;
    localparam int STAT_RES_EMPTY   = 17;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_POP,
        ST_ACK
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    cksum_pkg::reg_addr_e      addr;
    logic                      req_live;
    logic [`CKSUM_DATA_W-1:0]  status_word;
    logic [`CKSUM_DATA_W-1:0]  rd_word;

    assign req_live = wb_req.cyc && wb_req.stb;
    assign addr     = cksum_pkg::reg_addr_e'(wb_req.adr);

    ////////////////////////////////
    // Transaction FSM
    ////////////////////////////////
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (req_live)
                begin
                    // Byte write waits here while the input FIFO is full
                    if (wb_req.we && addr == cksum_pkg::REG_DATA)
                    begin
                        if (!in_full)
                            state_d = ST_ACK;
                    end
                    else if (!wb_req.we && addr == cksum_pkg::REG_RESULT)
                        state_d = ST_WAIT_POP;
                    else
                        state_d = ST_ACK;
                end
            end
            // Stalls until the engine delivers a checksum
            ST_WAIT_POP:
            begin
                if (!res_empty)
                    state_d = ST_ACK;
            end
            // Single cycle ack, back to idle
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    ////////////////////////////////
    // FIFO strobes
    ////////////////////////////////
    // Slot was checked when leaving idle, only this block pushes
    assign in_push      = (state_q == ST_ACK) && wb_req.we && addr == cksum_pkg::REG_DATA;
    assign in_data.data = wb_req.dat[7:0];
    assign in_data.last = wb_req.dat[8];
    // FIFO read register is valid in the ack cycle that follows
    assign res_pop      = (state_q == ST_WAIT_POP) && !res_empty;

    ////////////////////////////////
    // Read data
    ////////////////////////////////
    always_comb
    begin
        status_word = '0;
        status_word[STAT_IN_LVL_LSB +: IN_LVL_W]   = in_level;
        status_word[STAT_RES_LVL_LSB +: RES_LVL_W] = res_level;
        status_word[STAT_IN_FULL]                  = in_full;
        status_word[STAT_RES_EMPTY]                = res_empty;
    end

    always_comb
    begin
        rd_word = '0;
        // Writes and reads of DATA return zero
        if (!wb_req.we)
        begin
            case (addr)
                cksum_pkg::REG_RESULT: rd_word = {{(`CKSUM_DATA_W-RES_W){1'b0}}, res_data};
                cksum_pkg::REG_STATUS: rd_word = status_word;
                default:               rd_word = '0;
            endcase
        end
    end

    assign wb_rsp.ack = (state_q == ST_ACK);
    assign wb_rsp.dat = wb_rsp.ack ? rd_word : '0;

endmodule

`default_nettype wire

//--- source/cksum_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cksum_defines.svh"

module cksum_top
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire cksum_pkg::wb_req_t  wb_req,
    output cksum_pkg::wb_rsp_t       wb_rsp
);

    localparam int IN_LVL_W  = $clog2(`CKSUM_IN_DEPTH) + 1;
    localparam int RES_LVL_W = $clog2(`CKSUM_RES_DEPTH) + 1;

    ////////////////////////////////
    // Input FIFO nets
    ////////////////////////////////
    logic                   in_push;
    cksum_pkg::in_item_t    in_wr;
    logic                   in_pop;
    cksum_pkg::in_item_t    in_rd;
    logic                   in_empty;
    logic                   in_full;
    logic [IN_LVL_W-1:0]    in_level;

    ////////////////////////////////
    // Result FIFO nets
    ////////////////////////////////
    logic                   res_push;
    cksum_pkg::res_item_t   res_wr;
    logic                   res_pop;
    cksum_pkg::res_item_t   res_rd;
    logic                   res_empty;
    logic                   res_full;
    logic [RES_LVL_W-1:0]   res_level;

    // Host side register block
    wb_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .in_push   (in_push),
        .in_data   (in_wr),
        .in_full   (in_full),
        .in_level  (in_level),
        .res_pop   (res_pop),
        .res_data  (res_rd),
        .res_empty (res_empty),
        .res_level (res_level)
    );

    // Packet bytes from host to engine
    sync_fifo #(
        .payload_t (cksum_pkg::in_item_t),
        .DEPTH     (`CKSUM_IN_DEPTH)
    ) in_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (in_push),
        .wr_data (in_wr),
        .pop     (in_pop),
        .rd_data (in_rd),
        .empty   (in_empty),
        .full    (in_full),
        .level   (in_level)
    );

    // Checksums from engine to host
    sync_fifo #(
        .payload_t (cksum_pkg::res_item_t),
        .DEPTH     (`CKSUM_RES_DEPTH)
    ) res_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (res_push),
        .wr_data (res_wr),
        .pop     (res_pop),
        .rd_data (res_rd),
        .empty   (res_empty),
        .full    (res_full),
        .level   (res_level)
    );

    fletcher_engine engine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_rd),
        .in_empty (in_empty),
        .in_pop   (in_pop),
        .res_full (res_full),
        .res_push (res_push),
        .res_data (res_wr)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
)
(
    output logic clk,
    output logic rst_n
);

    // Free running clock
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset is active high, released on a rising edge
    initial
    begin
        rst_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/cksum_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cksum_defines.svh"

module cksum_tb;

    // Cycle budget for each operation in the data file
    localparam int         CYCLES_PER_OP = 40;
    localparam logic [7:0] LFSR_SEED     = 8'd31;

    logic                clk;
    logic                rst_n;
    cksum_pkg::wb_req_t  wb_req;
    cksum_pkg::wb_rsp_t  wb_rsp;

    // Operations loaded from the data file
    byte                       op_q[$];
    logic [`CKSUM_DATA_W-1:0]  arg_a_q[$];
    logic [`CKSUM_DATA_W-1:0]  arg_b_q[$];

    logic [7:0]   lfsr_state;
    int unsigned  cycle_cnt;
    int unsigned  cycle_limit;

    tb_clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cksum_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        // Limit is zero until the data file is loaded
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "Cycle limit reached");
        end
    end

    //////////////////////////////
    // Idle gap source
    //////////////////////////////
    // Taps 8,6,5,4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    // Two bits, one step per bit
    task automatic pick_gap(output int gap);
        int i;
        gap = 0;
        for (i = 0; i < 2; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            gap = (gap << 1) | int'(lfsr_state[0]);
        end
    endtask

    //////////////////////////////
    // Data file
    //////////////////////////////
    // Lines are W byte last, R checksum or S status, # starts a comment
    task automatic load_testdata();
        int                        fd;
        int                        n;
        byte                       op;
        string                     rest;
        logic [`CKSUM_DATA_W-1:0]  a;
        logic [`CKSUM_DATA_W-1:0]  b;
        logic                      done;
        logic                      bad;
        done = 1'b0;
        bad  = 1'b0;
        fd   = $fopen("bench/cksum_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the data file bench/cksum_testdata.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "Missing data file");
        end
        else
        begin
            while (!done && !bad)
            begin
                a = '0;
                b = '0;
                n = $fscanf(fd, " %c", op);
                if (n != 1)
                    done = 1'b1;
                else if (op == "#")
                    n = $fgets(rest, fd);
                else if (op == "W" || op == "R" || op == "S")
                begin
                    // Writes carry two operands, reads one
                    if (op == "W")
                        bad = ($fscanf(fd, "%h %h", a, b) != 2);
                    else
                        bad = ($fscanf(fd, "%h", a) != 1);
                    op_q.push_back(op);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                end
                else
                    bad = 1'b1;
            end
            $fclose(fd);
            if (bad || op_q.size() == 0)
            begin
                $display("The data file holds a malformed line or no operations");
                $display("TESTBENCH FAILED");
                $fatal(1, "Bad data file");
            end
        end
    endtask

    //////////////////////////////
    // Bus master
    //////////////////////////////
    // One classic cycle, request held until ack, outputs sampled on falling edge
    task automatic bus_cycle(input logic we, input cksum_pkg::reg_addr_e adr,
                             input logic [`CKSUM_DATA_W-1:0] wdat,
                             output logic [`CKSUM_DATA_W-1:0] rdat);
        cksum_pkg::wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        @(posedge clk);
        wb_req <= req;
        do
            @(negedge clk);
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        // Drop the strobe so the slave does not see a second request
        @(posedge clk);
        wb_req <= '0;
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_result(input cksum_pkg::res_item_t got,
                                input cksum_pkg::res_item_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: wb_rsp.dat RESULT is %h, expected %h",
                     $time, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Checksum mismatch");
        end
    endtask

    task automatic check_status(input logic [`CKSUM_DATA_W-1:0] got,
                                input logic [`CKSUM_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: wb_rsp.dat STATUS is %h, expected %h",
                     $time, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Status mismatch");
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        int                        idx;
        int                        gap;
        logic [`CKSUM_DATA_W-1:0]  rd_word;
        wb_req      = '0;
        lfsr_state  = LFSR_SEED;
        cycle_cnt   = 0;
        cycle_limit = 0;
        load_testdata();
        cycle_limit = op_q.size() * CYCLES_PER_OP;
        // Wait for reset release
        wait (rst_n == 1'b0);
        for (idx = 0; idx < op_q.size(); idx++)
        begin
            // RESULT reads go out at once so they catch a packet still in the engine
            if (op_q[idx] != "R")
            begin
                pick_gap(gap);
                repeat (gap) @(posedge clk);
            end
            case (op_q[idx])
                "W":
                    bus_cycle(1'b1, cksum_pkg::REG_DATA,
                              {23'd0, arg_b_q[idx][0], arg_a_q[idx][7:0]}, rd_word);
                "R":
                begin
                    // May stall until the engine finishes the packet
                    bus_cycle(1'b0, cksum_pkg::REG_RESULT, '0, rd_word);
                    check_result(rd_word[15:0], arg_a_q[idx][15:0]);
                end
                default:
                begin
                    bus_cycle(1'b0, cksum_pkg::REG_STATUS, '0, rd_word);
                    check_status(rd_word, arg_a_q[idx]);
                end
            endcase
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/cksum_testdata.txt
# Columns: opcode, then hex operands
# W byte last | R expected checksum (sum2 sum1) | S expected status word
# Status right after reset
S 00020000
# Single packet 01..05
W 01 0
W 02 0
W 03 0
W 04 0
W 05 1
R 230f
# Three packets queued before any read
W ff 0
W 01 1
W 80 1
W 10 0
W 20 0
W 30 1
R 0101
R 8080
R a060
S 00020000
# Fill the result FIFO, then fill the input FIFO behind it
W 11 1
W 22 1
W 33 1
W 44 1
W 01 0
W 01 0
W 01 0
W 01 1
W fe 0
W fe 0
W fe 0
W fe 1
S 00010408
R 1111
R 2222
R 3333
R 4444
R 0a04
R f5fb
S 00020000
# Read issued right behind the last byte
W 12 0
W 34 0
W 56 0
W 78 0
W 9a 0
W bc 1
R 266c
S 00020000

//--- project.f
+incdir+common
common/cksum_pkg.sv
source/sync_fifo.sv
source/fletcher_engine.sv
source/wb_ctrl.sv
source/cksum_top.sv
bench/tb_clock_gen.sv
bench/cksum_tb.sv
